// File: src.f
+incdir+.
sv32_pkg.sv
mmu_req_pkg.sv
tlb_cache.sv
page_walker.sv
translate_ctrl.sv
mmu_top.sv
tb_mmu.sv

// File: run.sh
#!/bin/sh
# builds the MMU testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary -f src.f --top-module tb_mmu -o tb_mmu_sim

out=$(./obj_dir/tb_mmu_sim)
echo "$out"
echo "$out" | grep -q "Testbench passed"

// File: tb_mmu.sv
/* Random Sv32 walks checked against a page-table model held in a small memory.
   Page tables live in physical pages 0x10..0x1f; any other walker address is an error. */

module tb_mmu;
    import sv32_pkg::*;
    import mmu_req_pkg::*;

    localparam ppn_t ROOT_PPN = 20'h00010;
    localparam int   WORDS    = 16 * 1024;
    localparam int   TIMEOUT  = 100;
    localparam int   ROUNDS   = 60;

    logic    CLK       = 1'b0;
    logic    rst_n     = 1'b0;
    access_t access    = ACC_NONE;
    vaddr_t  vaddr     = '0;
    priv_t   priv      = PRIV_M;
    logic    satp_mode = 1'b0;
    ppn_t    satp_ppn  = ROOT_PPN;
    logic    sum       = 1'b0;
    logic    mxr       = 1'b0;
    logic    flush     = 1'b0;
    pte_t    mem_rdata = '0;
    logic    mem_ack   = 1'b0;
    logic    done;
    logic    fault;
    logic    mem_rd;
    logic    mem_wr;
    paddr_t  paddr;
    paddr_t  mem_addr;
    cause_t  cause;
    pte_t    mem_wdata;

    logic [31:0] mem [WORDS];
    logic [31:0] rng = 32'h66b0_cc8b;
    int          ack_wait  = -1;
    int          strobes   = 0;
    int          reads     = 0;
    int          writes    = 0;
    paddr_t      wr_addr;
    pte_t        wr_data;
    int          err_value = 0;
    int          err_other = 0;
    logic        abort     = 1'b0;

    mmu_top mmu_top_i (.*);

    always #2 CLK = ~CLK;

    function automatic logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // memory port that acks 1 to 3 cycles after it sees a strobe and applies writes
    always begin
        @(posedge CLK);
        #1;
        if (mem_ack) begin
            mem_ack = 1'b0;
        end else if (mem_rd || mem_wr) begin
            strobes++;
            if (mem_rd && mem_wr) begin
                $display("walker raised read and write strobes together");
                err_other++;
            end
            if (ack_wait < 0) begin
                ack_wait = int'(rand32() % 3);
            end
            if (ack_wait > 0) begin
                ack_wait--;
            end else begin
                ack_wait = -1;
                mem_ack  = 1'b1;
                if (mem_addr[31:16] != 16'h0001 || mem_addr[1:0] != 2'b00) begin
                    $display("walker address %h lies outside the page tables", mem_addr);
                    err_other++;
                end else if (mem_wr) begin
                    mem[mem_addr[15:2]] = mem_wdata;
                    writes++;
                    wr_addr = mem_addr;
                    wr_data = mem_wdata;
                end else begin
                    mem_rdata = mem[mem_addr[15:2]];
                    reads++;
                end
            end
        end
    end

    task automatic check_paddr(string name, paddr_t exp, paddr_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_cause(string name, cause_t exp, cause_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_pte(string name, pte_t exp, pte_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            err_value++;
        end
    endtask

    function automatic cause_t expected_cause(access_t acc);
        if (acc == ACC_CODE) begin
            return cause_t'(4'd12);
        end
        if (acc == ACC_READ) begin
            return cause_t'(4'd13);
        end
        return cause_t'(4'd15);
    endfunction

    // reference walk over the memory model with the current priv, sum and mxr
    task automatic model_walk(input access_t acc, input vaddr_t va, output paddr_t pa,
                              output logic flt, output int n_reads, output logic wb,
                              output paddr_t wb_addr, output pte_t wb_pte);
        pte_t       pte;
        paddr_t     addr;
        logic       mega;
        logic       allowed;
        logic [2:0] xwr;
        addr    = {ROOT_PPN, va[31:22], 2'b00};
        pte     = mem[addr[15:2]];
        mega    = 1'b1;
        n_reads = 1;
        if (pte.v && !pte.r && !pte.w && !pte.x) begin
            addr    = {pte.ppn, va[21:12], 2'b00};
            pte     = mem[addr[15:2]];
            mega    = 1'b0;
            n_reads = 2;
        end
        xwr = {pte.x, pte.w, pte.r};
        if (acc == ACC_CODE) begin
            allowed = pte.x;
        end else if (acc == ACC_WRITE) begin
            allowed = pte.w;
        end else begin
            allowed = pte.r || (mxr && pte.x);
        end
        flt = !pte.v || (xwr == 3'b000) || (xwr == 3'b010) || (xwr == 3'b110) || !allowed
            || (priv == PRIV_S && pte.u && !sum) || (priv == PRIV_U && !pte.u);
        pa = mega ? {pte.ppn[19:10], va[21:0]} : {pte.ppn, va[11:0]};
        wb = !flt && (!pte.a || (acc == ACC_WRITE && !pte.d));
        wb_addr  = addr;
        wb_pte   = pte;
        wb_pte.a = 1'b1;
        if (acc == ACC_WRITE) begin
            wb_pte.d = 1'b1;
        end
    endtask

    // holds the request until done, then one idle cycle so stray strobes get counted
    task automatic access_once(input access_t acc, input vaddr_t va, output int cycles);
        strobes = 0;
        reads   = 0;
        writes  = 0;
        access  = acc;
        vaddr   = va;
        cycles  = 0;
        do begin
            @(posedge CLK);
            #1;
            cycles++;
        end while (!done && cycles < TIMEOUT);
        access = ACC_NONE;
        if (!done) begin
            $display("no done within %0d cycles for vaddr %h", TIMEOUT, va);
            err_other++;
            abort = 1'b1;
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
    endtask

    task automatic run_bare(string name, priv_t p, logic mode);
        vaddr_t va;
        int     cycles;
        if (abort) begin
            return;
        end
        priv      = p;
        satp_mode = mode;
        va        = rand32();
        access_once(ACC_READ, va, cycles);
        check_paddr({name, " paddr"}, va, paddr);
        check_flag({name, " fault"}, 1'b0, fault);
        check_count({name, " cycles"}, 1, cycles);
        check_count({name, " strobes"}, 0, strobes);
    endtask

    // hit means the TLB should answer in one cycle with no memory traffic
    task automatic run_translated(input string name, input access_t acc, input vaddr_t va,
                                  input logic hit, output logic flt);
        paddr_t exp_pa;
        paddr_t wb_addr;
        pte_t   wb_pte;
        logic   wb;
        int     n_reads;
        int     cycles;
        flt = 1'b1;
        if (abort) begin
            return;
        end
        model_walk(acc, va, exp_pa, flt, n_reads, wb, wb_addr, wb_pte);
        access_once(acc, va, cycles);
        if (abort) begin
            return;
        end
        check_flag({name, " fault"}, flt, fault);
        if (flt) begin
            check_cause({name, " cause"}, expected_cause(acc), cause);
        end else begin
            check_paddr({name, " paddr"}, exp_pa, paddr);
        end
        if (hit) begin
            check_count({name, " cycles"}, 1, cycles);
            check_count({name, " strobes"}, 0, strobes);
        end else begin
            check_count({name, " reads"}, n_reads, reads);
            check_count({name, " writes"}, wb ? 1 : 0, writes);
            if (wb && writes == 1) begin
                check_paddr({name, " write-back address"}, wb_addr, wr_addr);
                check_pte({name, " write-back PTE"}, wb_pte, wr_data);
            end
        end
    endtask

    // root entry plus leaf; about half the leaves are forced to a usable RWX page
    task automatic build_page(input logic mega, output vaddr_t va);
        pte_t root;
        pte_t leaf;
        va     = rand32();
        leaf   = rand32();
        leaf.v = (rand32() % 8) != 0;
        if ((rand32() % 2) == 0) begin
            leaf.v = 1'b1;
            leaf.r = 1'b1;
            leaf.w = 1'b1;
            leaf.x = 1'b1;
            leaf.u = (priv == PRIV_U);
        end
        if (mega) begin
            if (!leaf.r && !leaf.w && !leaf.x) begin
                leaf.r = 1'b1;
            end
            mem[{ROOT_PPN[3:0], va[31:22]}] = leaf;
        end else begin
            root      = '0;
            root.v    = (rand32() % 16) != 0;
            root.ppn  = ROOT_PPN + 20'd1 + 20'(rand32() % 15);
            mem[{ROOT_PPN[3:0], va[31:22]}] = root;
            mem[{root.ppn[3:0], va[21:12]}] = leaf;
        end
    endtask

    // miss, repeat, same page with another access kind, then a walk after a flush
    task automatic run_round(int i);
        logic [31:0] r;
        access_t     acc;
        access_t     other;
        vaddr_t      va;
        logic        flt;
        logic        flt_next;
        string       tag;
        r    = rand32();
        sum  = r[0];
        mxr  = r[1];
        priv = r[2] ? PRIV_U : PRIV_S;
        case (r[4:3])
            2'd0:    acc = ACC_CODE;
            2'd1:    acc = ACC_READ;
            default: acc = ACC_WRITE;
        endcase
        other = (acc == ACC_WRITE) ? ACC_CODE : access_t'(acc + 2'd1);
        tag   = $sformatf("round %0d", i);
        pulse_flush();
        build_page(i % 4 == 0, va);
        run_translated({tag, " miss"}, acc, va, 1'b0, flt);
        // a fault fills nothing, so the repeat walks again
        run_translated({tag, " repeat"}, acc, va, !flt, flt_next);
        if (!flt) begin
            run_translated({tag, " other kind"}, other, va, 1'b0, flt_next);
            pulse_flush();
            run_translated({tag, " after flush"}, acc, va, 1'b0, flt_next);
        end
    endtask

    initial begin
        repeat (2) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        run_bare("bare M mode", PRIV_M, 1'b1);
        run_bare("bare satp off", PRIV_S, 1'b0);
        satp_mode = 1'b1;
        for (int i = 0; i < ROUNDS && !abort; i++) begin
            run_round(i);
        end
        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: mmu_top.sv
/* Sv32 MMU top: separate fetch, load and store TLBs over one walker and memory port.
   flush must only pulse while access is ACC_NONE. */

`include "mmu_settings.svh"

module mmu_top (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  mmu_req_pkg::access_t access,
    input  sv32_pkg::vaddr_t     vaddr,
    input  mmu_req_pkg::priv_t   priv,
    input  logic                 satp_mode,
    input  sv32_pkg::ppn_t       satp_ppn,
    input  logic                 sum,
    input  logic                 mxr,
    input  logic                 flush,
    output logic                 done,
    output sv32_pkg::paddr_t     paddr,
    output logic                 fault,
    output mmu_req_pkg::cause_t  cause,
    output logic                 mem_rd,
    output logic                 mem_wr,
    output sv32_pkg::paddr_t     mem_addr,
    output sv32_pkg::pte_t       mem_wdata,
    input  sv32_pkg::pte_t       mem_rdata,
    input  logic                 mem_ack
);
    import sv32_pkg::*;

    vpn_t page_vpn;
    logic hit_code, hit_read, hit_write;
    ppn_t ppn_code, ppn_read, ppn_write;
    logic we_code, we_read, we_write;
    logic walk_start, walk_done, walk_fault;
    ppn_t walk_ppn;

    assign page_vpn = vaddr[$bits(vaddr_t)-1:`MMU_PAGE_BITS];

    // all three refill from the walker result
    tlb_cache #(.ENTRIES(`MMU_TLB_ENTRIES)) tlb_code (
        .CLK(CLK), .rst_n(rst_n), .flush(flush), .we(we_code),
        .lookup_vpn(page_vpn), .fill_ppn(walk_ppn), .hit(hit_code), .ppn(ppn_code)
    );

    tlb_cache #(.ENTRIES(`MMU_TLB_ENTRIES)) tlb_read (
        .CLK(CLK), .rst_n(rst_n), .flush(flush), .we(we_read),
        .lookup_vpn(page_vpn), .fill_ppn(walk_ppn), .hit(hit_read), .ppn(ppn_read)
    );

    tlb_cache #(.ENTRIES(`MMU_TLB_ENTRIES)) tlb_write (
        .CLK(CLK), .rst_n(rst_n), .flush(flush), .we(we_write),
        .lookup_vpn(page_vpn), .fill_ppn(walk_ppn), .hit(hit_write), .ppn(ppn_write)
    );

    page_walker page_walker_i (
        .CLK(CLK), .rst_n(rst_n), .walk_start(walk_start), .vaddr(vaddr),
        .access(access), .priv(priv), .satp_ppn(satp_ppn), .sum(sum), .mxr(mxr),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_ack(mem_ack), .walk_done(walk_done),
        .walk_ppn(walk_ppn), .walk_fault(walk_fault)
    );

    translate_ctrl translate_ctrl_i (
        .CLK(CLK), .rst_n(rst_n), .access(access), .vaddr(vaddr), .priv(priv),
        .satp_mode(satp_mode), .hit_code(hit_code), .hit_read(hit_read),
        .hit_write(hit_write), .ppn_code(ppn_code), .ppn_read(ppn_read),
        .ppn_write(ppn_write), .walk_start(walk_start), .walk_done(walk_done),
        .walk_ppn(walk_ppn), .walk_fault(walk_fault), .we_code(we_code),
        .we_read(we_read), .we_write(we_write), .done(done), .paddr(paddr),
        .fault(fault), .cause(cause)
    );

endmodule

// File: translate_ctrl.sv
/* Picks bare, TLB-hit or walk results and refills the TLB of the access kind.
   access, vaddr, priv and satp_mode are held by the core until done. */

`include "mmu_settings.svh"

module translate_ctrl (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  mmu_req_pkg::access_t access,
    input  sv32_pkg::vaddr_t     vaddr,
    input  mmu_req_pkg::priv_t   priv,
    input  logic                 satp_mode,
    input  logic                 hit_code,
    input  logic                 hit_read,
    input  logic                 hit_write,
    input  sv32_pkg::ppn_t       ppn_code,
    input  sv32_pkg::ppn_t       ppn_read,
    input  sv32_pkg::ppn_t       ppn_write,
    output logic                 walk_start,
    input  logic                 walk_done,
    input  sv32_pkg::ppn_t       walk_ppn,
    input  logic                 walk_fault,
    output logic                 we_code,
    output logic                 we_read,
    output logic                 we_write,
    output logic                 done,
    output sv32_pkg::paddr_t     paddr,
    output logic                 fault,
    output mmu_req_pkg::cause_t  cause
);
    import sv32_pkg::*;
    import mmu_req_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WALK,
        ST_DONE
    } state_t;

    state_t state;
    logic   bare;
    logic   kind_hit;
    ppn_t   kind_ppn;
    logic   request;
    logic   refill;

    always_comb begin
        case (access)
            ACC_CODE: begin
                kind_hit = hit_code;
                kind_ppn = ppn_code;
            end
            ACC_READ: begin
                kind_hit = hit_read;
                kind_ppn = ppn_read;
            end
            default: begin
                kind_hit = hit_write;
                kind_ppn = ppn_write;
            end
        endcase
    end

    assign bare       = (priv == PRIV_M) || !satp_mode;
    assign request    = (state == ST_IDLE) && (access != ACC_NONE);
    assign walk_start = request && !bare && !kind_hit;

    // only a clean walk fills, and only the TLB of this access kind
    assign refill   = (state == ST_WALK) && walk_done && !walk_fault;
    assign we_code  = refill && (access == ACC_CODE);
    assign we_read  = refill && (access == ACC_READ);
    assign we_write = refill && (access == ACC_WRITE);

    assign done = (state == ST_DONE);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            fault <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (request) begin
                        fault <= 1'b0;
                        state <= (bare || kind_hit) ? ST_DONE : ST_WALK;
                    end
                end
                ST_WALK: begin
                    if (walk_done) begin
                        fault <= walk_fault;
                        state <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (request) begin
            paddr <= bare ? vaddr : {kind_ppn, vaddr[`MMU_PAGE_BITS-1:0]};
        end else if (state == ST_WALK && walk_done) begin
            paddr <= {walk_ppn, vaddr[`MMU_PAGE_BITS-1:0]};
            cause <= cause_of(access);
        end
    end

endmodule

// File: page_walker.sv
/* Two-level Sv32 walk on one memory port, then the A/D write-back of the leaf.
   vaddr, access, priv, satp_ppn, sum and mxr must stay stable from walk_start to walk_done.
   Megapage alignment of the leaf PPN is not checked. */

`include "mmu_settings.svh"

module page_walker (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 walk_start,
    input  sv32_pkg::vaddr_t     vaddr,
    input  mmu_req_pkg::access_t access,
    input  mmu_req_pkg::priv_t   priv,
    input  sv32_pkg::ppn_t       satp_ppn,
    input  logic                 sum,
    input  logic                 mxr,
    output logic                 mem_rd,
    output logic                 mem_wr,
    output sv32_pkg::paddr_t     mem_addr,
    output sv32_pkg::pte_t       mem_wdata,
    input  sv32_pkg::pte_t       mem_rdata,
    input  logic                 mem_ack,
    output logic                 walk_done,
    output sv32_pkg::ppn_t       walk_ppn,
    output logic                 walk_fault
);
    import sv32_pkg::*;
    import mmu_req_pkg::*;

    typedef enum logic [2:0] {
        WK_IDLE,
        WK_READ,
        WK_CHECK,
        WK_WRITE,
        WK_DONE
    } wk_state_t;

    wk_state_t state;
    logic      level;
    logic      fault_q;
    pte_t      pte_q;
    paddr_t    pte_addr_q;
    ppn_t      ppn_q;

    vpn_part_t vpn1;
    vpn_part_t vpn0;
    logic      go_down;
    logic      perm_ok;
    logic      bad;
    logic      need_wb;

    assign vpn0 = vaddr[`MMU_PAGE_BITS +: $bits(vpn_part_t)];
    assign vpn1 = vaddr[`MMU_PAGE_BITS + $bits(vpn_part_t) +: $bits(vpn_part_t)];

    // leaf checks on the PTE that was just read
    always_comb begin
        go_down = pte_q.v && !pte_is_leaf(pte_q) && level;
        case (access)
            ACC_CODE:  perm_ok = pte_q.x;
            ACC_WRITE: perm_ok = pte_q.w;
            default:   perm_ok = pte_q.r | (mxr & pte_q.x);
        endcase
        // XWR 010 and 110 are reserved, i.e. W without R
        bad = !pte_q.v || !pte_is_leaf(pte_q) || (pte_q.w && !pte_q.r) || !perm_ok
            || (priv == PRIV_S && pte_q.u && !sum)
            || (priv == PRIV_U && !pte_q.u);
        need_wb = !pte_q.a || (access == ACC_WRITE && !pte_q.d);
    end

    always_comb begin
        mem_wdata   = pte_q;
        mem_wdata.a = 1'b1;
        if (access == ACC_WRITE) begin
            mem_wdata.d = 1'b1;
        end
    end

    // the same address serves the PTE read and its write-back
    assign mem_addr   = pte_addr_q;
    assign mem_rd     = (state == WK_READ);
    assign mem_wr     = (state == WK_WRITE);
    assign walk_done  = (state == WK_DONE);
    assign walk_ppn   = ppn_q;
    assign walk_fault = fault_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state   <= WK_IDLE;
            level   <= 1'b1;
            fault_q <= 1'b0;
        end else begin
            case (state)
                WK_IDLE: begin
                    if (walk_start) begin
                        level   <= 1'b1;
                        fault_q <= 1'b0;
                        state   <= WK_READ;
                    end
                end
                WK_READ: begin
                    if (mem_ack) begin
                        state <= WK_CHECK;
                    end
                end
                WK_CHECK: begin
                    if (go_down) begin
                        level <= 1'b0;
                        state <= WK_READ;
                    end else if (bad) begin
                        fault_q <= 1'b1;
                        state   <= WK_DONE;
                    end else if (need_wb) begin
                        state <= WK_WRITE;
                    end else begin
                        state <= WK_DONE;
                    end
                end
                WK_WRITE: begin
                    if (mem_ack) begin
                        state <= WK_DONE;
                    end
                end
                default: state <= WK_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == WK_IDLE && walk_start) begin
            pte_addr_q <= pte_addr(satp_ppn, vpn1);
        end
        if (state == WK_CHECK && go_down) begin
            pte_addr_q <= pte_addr(pte_q.ppn, vpn0);
        end
        if (state == WK_READ && mem_ack) begin
            pte_q <= mem_rdata;
        end
        // megapage keeps vpn0 from the virtual address
        if (state == WK_CHECK) begin
            ppn_q <= level ? {pte_q.ppn[$bits(ppn_t)-1 -: $bits(vpn_part_t)], vpn0}
                           : pte_q.ppn;
        end
    end

endmodule

// File: tlb_cache.sv
/* Direct-mapped TLB with combinational lookup. ENTRIES must be a power of two.
   Writes and flushes land at the next clock edge; a flush wins over nothing else. */

`include "mmu_settings.svh"

module tlb_cache #(
    parameter int ENTRIES = `MMU_TLB_ENTRIES
) (
    input  logic           CLK,
    input  logic           rst_n,
    input  logic           flush,
    input  logic           we,
    input  sv32_pkg::vpn_t lookup_vpn,
    input  sv32_pkg::ppn_t fill_ppn,
    output logic           hit,
    output sv32_pkg::ppn_t ppn
);
    import sv32_pkg::*;

    localparam int IDX_BITS = $clog2(ENTRIES);
    localparam int TAG_BITS = $bits(vpn_t) - IDX_BITS;

    logic [ENTRIES-1:0]  valid;
    logic [TAG_BITS-1:0] tag_mem [ENTRIES];
    ppn_t                ppn_mem [ENTRIES];

    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;

    // low vpn bits pick the entry
    assign {tag, idx} = lookup_vpn;

    assign hit = valid[idx] && (tag_mem[idx] == tag);
    assign ppn = ppn_mem[idx];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (flush) begin
                valid <= '0;
            end
            if (we) begin
                valid[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (we) begin
            tag_mem[idx] <= tag;
            ppn_mem[idx] <= fill_ppn;
        end
    end

endmodule

// File: mmu_req_pkg.sv
/* Request side of the MMU: access kind, privilege level and page-fault cause.
   Cause values follow the RISC-V mcause encoding for page faults. */

package mmu_req_pkg;

    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_CODE  = 2'd1,
        ACC_READ  = 2'd2,
        ACC_WRITE = 2'd3
    } access_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    typedef enum logic [3:0] {
        CAUSE_FETCH_PF = 4'd12,
        CAUSE_LOAD_PF  = 4'd13,
        CAUSE_STORE_PF = 4'd15
    } cause_t;

    function automatic cause_t cause_of(access_t acc);
        case (acc)
            ACC_CODE: return CAUSE_FETCH_PF;
            ACC_READ: return CAUSE_LOAD_PF;
            default:  return CAUSE_STORE_PF;
        endcase
    endfunction

endpackage

// File: sv32_pkg.sv
/* Sv32 memory format: addresses, page numbers and the page-table entry.
   PTE bits 31:30 lie beyond the 32-bit physical space and are ignored by the walker. */

`include "mmu_settings.svh"

package sv32_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    typedef logic [`MMU_VPN_BITS-1:0] vpn_t;
    typedef logic [`MMU_PPN_BITS-1:0] ppn_t;

    // one level's index into a page table (vpn1 or vpn0)
    typedef logic [`MMU_VPN_BITS/2-1:0] vpn_part_t;

    typedef struct packed {
        logic [1:0] ppn_ext;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // address of entry idx in the table at page table_ppn, 4 bytes per PTE
    function automatic paddr_t pte_addr(ppn_t table_ppn, vpn_part_t idx);
        return {table_ppn, {`MMU_PAGE_BITS{1'b0}}} + paddr_t'({idx, 2'b00});
    endfunction

    // any of R, W, X set marks a leaf
    function automatic logic pte_is_leaf(pte_t pte);
        return pte.r | pte.w | pte.x;
    endfunction

endpackage

// File: mmu_settings.svh
/* Sizing for the Sv32 MMU. PPN plus page bits must give a 32-bit physical address,
   and the TLB entry count must be a power of two of at least 2. */

`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// entries in each of the fetch, load and store TLBs
`define MMU_TLB_ENTRIES 8

// 4 KiB pages
`define MMU_PAGE_BITS 12

// vpn1 and vpn0 split this evenly
`define MMU_VPN_BITS 20

// only the low 20 PPN bits of a PTE are used, since physical addresses are 32 bits
`define MMU_PPN_BITS 20

`endif
